/* hw/axi_read_pkg.sv */
package axi_read_pkg;

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int OFFSET_W   = 2;    // Byte lanes of a 32-bit word
   localparam int AXI_LEN_W  = 8;
   localparam int XFER_LEN_W = 12;
   localparam int MAX_BEATS  = 16;
   localparam int BOUNDARY_W = 12;   // 4 KB page

   // Byte count including the leading offset, and the beats it spans
   localparam int REM_W   = XFER_LEN_W + 1;
   localparam int BEATS_W = REM_W - OFFSET_W;

   localparam logic [2:0] AXI_SIZE       = 3'($clog2(DATA_W / 8));
   localparam logic [1:0] AXI_BURST_INCR = 2'b01;
   localparam logic [3:0] AXI_CACHE      = 4'b0010;   // Normal non-cacheable
   localparam logic [2:0] AXI_PROT       = 3'b010;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [OFFSET_W-1:0]   offset_t;
   typedef logic [AXI_LEN_W-1:0]  axi_len_t;
   typedef logic [XFER_LEN_W-1:0] xfer_len_t;
   typedef logic [BEATS_W-1:0]    beat_cnt_t;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_PREP,
      RD_ADDR,
      RD_DATA
   } read_state_t;

endpackage

/* hw/burst_ctrl_if.sv */
`timescale 1ns/1ns

interface burst_ctrl_if;
   import axi_read_pkg::*;

   logic     start_transfer;   // Load address and count
   logic     start_burst;      // AR handshake
   addr_t    burst_addr;
   axi_len_t burst_len;
   logic     last_burst;       // Current burst ends the transfer

   modport ctrl (
      output start_transfer,
      output start_burst,
      input  burst_addr,
      input  burst_len,
      input  last_burst
   );

   modport cnt (
      input  start_transfer,
      input  start_burst,
      output burst_addr,
      output burst_len,
      output last_burst
   );

endinterface

/* hw/read_fsm.sv */
`timescale 1ns/1ns

module read_fsm (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     req_valid_i,
   input  logic                     align_empty_i,
   input  logic                     arready_i,
   input  logic                     rvalid_i,
   input  logic                     rlast_i,
   output logic                     arvalid_o,
   output logic                     rready_o,
   burst_ctrl_if.ctrl               bus,
   output axi_read_pkg::read_state_t state_o
);
   import axi_read_pkg::*;

   read_state_t state_q;
   logic        arvalid_q;
   logic        burst_done;

   // New request only once the aligner has drained the previous one
   assign bus.start_transfer = (state_q == RD_IDLE) && req_valid_i && align_empty_i;
   assign bus.start_burst    = (state_q == RD_ADDR) && arvalid_q && arready_i;

   assign burst_done = rvalid_i && rready_o && rlast_i;

   assign arvalid_o = arvalid_q;
   assign rready_o  = (state_q == RD_DATA);
   assign state_o   = state_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q   <= RD_IDLE;
         arvalid_q <= 1'b0;
      end else begin
         case (state_q)
            RD_IDLE: begin
               if (bus.start_transfer) begin
                  state_q <= RD_PREP;
               end
            end
            RD_PREP: begin
               // Burst length settles in this cycle
               arvalid_q <= 1'b1;
               state_q   <= RD_ADDR;
            end
            RD_ADDR: begin
               if (bus.start_burst) begin
                  arvalid_q <= 1'b0;
                  state_q   <= RD_DATA;
               end
            end
            RD_DATA: begin
               if (burst_done) begin
                  if (bus.last_burst) begin
                     state_q <= RD_IDLE;
                  end else begin
                     state_q <= RD_PREP;   // Next burst of the transfer
                  end
               end
            end
            default: begin
               state_q   <= RD_IDLE;
               arvalid_q <= 1'b0;
            end
         endcase
      end
   end

endmodule

/* hw/transfer_counter.sv */
`timescale 1ns/1ns

module transfer_counter (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  axi_read_pkg::addr_t     addr_i,
   input  axi_read_pkg::xfer_len_t len_i,
   burst_ctrl_if.cnt               bus
);
   import axi_read_pkg::*;

   addr_t            cur_addr_q;    // Word aligned
   logic [REM_W-1:0] rem_q;         // Bytes left from aligned address
   logic             last_q;
   axi_len_t         len_q;

   logic [REM_W-1:0] rem_round;
   logic [REM_W-1:0] burst_bytes;
   beat_cnt_t        rem_beats;
   beat_cnt_t        bound_beats;
   beat_cnt_t        beats;
   logic             covers_all;

   always_comb begin
      rem_round = rem_q + REM_W'(2 ** OFFSET_W - 1);
      rem_beats = rem_round[REM_W-1:OFFSET_W];

      // Beats until the next 4 KB page
      bound_beats = BEATS_W'(2 ** (BOUNDARY_W - OFFSET_W))
                  - BEATS_W'(cur_addr_q[BOUNDARY_W-1:OFFSET_W]);

      beats = rem_beats;
      if (beats > BEATS_W'(MAX_BEATS)) begin
         beats = BEATS_W'(MAX_BEATS);
      end
      if (beats > bound_beats) begin
         beats = bound_beats;
      end

      covers_all  = (beats == rem_beats);
      burst_bytes = {beats, {OFFSET_W{1'b0}}};
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         cur_addr_q <= '0;
         rem_q      <= '0;
         last_q     <= 1'b0;
      end else if (bus.start_transfer) begin
         cur_addr_q <= {addr_i[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
         rem_q      <= REM_W'(len_i) + REM_W'(addr_i[OFFSET_W-1:0]);
         last_q     <= 1'b0;
      end else if (bus.start_burst) begin
         cur_addr_q <= cur_addr_q + ADDR_W'(burst_bytes);
         last_q     <= covers_all;   // Holds for the data phase of this burst
         if (covers_all) begin
            rem_q <= '0;
         end else begin
            rem_q <= rem_q - burst_bytes;
         end
      end
   end

   // Registered length, stable from the end of RD_PREP through the AR handshake
   always_ff @(posedge clk_i) begin
      len_q <= axi_len_t'(beats - BEATS_W'(1));
   end

   assign bus.burst_addr = cur_addr_q;
   assign bus.burst_len  = len_q;
   assign bus.last_burst = last_q;

endmodule

/* hw/burst_align.sv */
`timescale 1ns/1ns

module burst_align (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  axi_read_pkg::offset_t   offset_i,
   input  axi_read_pkg::xfer_len_t len_i,
   input  logic                    start_i,
   input  logic                    beat_valid_i,
   input  axi_read_pkg::data_t     beat_data_i,
   output axi_read_pkg::data_t     word_o,
   output logic                    word_valid_o,
   output logic                    word_last_o,
   output logic                    empty_o
);
   import axi_read_pkg::*;

   offset_t   offset_q;
   offset_t   tail_q;          // Valid bytes in last word, zero for all
   data_t     prev_q;
   beat_cnt_t beats_left_q;
   beat_cnt_t words_left_q;
   logic      first_q;         // No previous beat yet
   logic      flush_q;

   logic [REM_W-1:0]    beats_round;
   logic [REM_W-1:0]    words_round;
   data_t               new_data;
   logic [2*DATA_W-1:0] pair;
   data_t               shifted;
   data_t               keep_mask;
   logic                emit_beat;
   logic                final_beat;
   logic                last_word;

   always_comb begin
      beats_round = REM_W'(len_i) + REM_W'(offset_i) + REM_W'(2 ** OFFSET_W - 1);
      words_round = REM_W'(len_i) + REM_W'(2 ** OFFSET_W - 1);

      // Flush word has no newer beat behind it
      new_data = flush_q ? data_t'(0) : beat_data_i;
      pair     = {new_data, prev_q};
      shifted  = data_t'(pair >> {offset_q, 3'b000});

      emit_beat  = beat_valid_i && !first_q && (words_left_q != '0);
      final_beat = beat_valid_i && (beats_left_q == BEATS_W'(1));
      last_word  = (words_left_q == BEATS_W'(1));

      for (int i = 0; i < DATA_W / 8; i++) begin
         if (tail_q == '0 || i < int'(tail_q)) begin
            keep_mask[8*i +: 8] = 8'hff;
         end else begin
            keep_mask[8*i +: 8] = 8'h00;
         end
      end
   end

   assign word_valid_o = emit_beat || flush_q;
   assign word_last_o  = word_valid_o && last_word;
   assign word_o       = last_word ? (shifted & keep_mask) : shifted;
   assign empty_o      = (words_left_q == '0);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         beats_left_q <= '0;
         words_left_q <= '0;
         first_q      <= 1'b0;
         flush_q      <= 1'b0;
      end else if (start_i) begin
         beats_left_q <= beats_round[REM_W-1:OFFSET_W];
         words_left_q <= words_round[REM_W-1:OFFSET_W];
         first_q      <= 1'b1;
         flush_q      <= 1'b0;
      end else begin
         if (beat_valid_i) begin
            beats_left_q <= beats_left_q - BEATS_W'(1);
            first_q      <= 1'b0;
         end
         if (word_valid_o) begin
            words_left_q <= words_left_q - BEATS_W'(1);
         end
         // One word still owed after the final beat
         flush_q <= final_beat && (words_left_q > BEATS_W'(emit_beat));
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i) begin
         offset_q <= offset_i;
         tail_q   <= len_i[OFFSET_W-1:0];
      end
      if (beat_valid_i) begin
         prev_q <= beat_data_i;
      end
   end

endmodule

/* hw/simple_axi_read.sv */
`timescale 1ns/1ns

module simple_axi_read (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // Simple side
   input  logic                    m_rvalid_i,
   input  axi_read_pkg::addr_t     m_raddr_i,
   input  axi_read_pkg::xfer_len_t m_rlen_i,
   output axi_read_pkg::data_t     m_rdata_o,
   output logic                    m_rready_o,
   output logic                    m_rlast_o,

   // AR channel
   output axi_read_pkg::addr_t     axi_araddr_o,
   output axi_read_pkg::axi_len_t  axi_arlen_o,
   output logic                    axi_arvalid_o,
   input  logic                    axi_arready_i,
   output logic [3:0]              axi_arid_o,
   output logic [2:0]              axi_arsize_o,
   output logic [1:0]              axi_arburst_o,
   output logic [3:0]              axi_arcache_o,
   output logic [2:0]              axi_arprot_o,

   // R channel
   input  axi_read_pkg::data_t     axi_rdata_i,
   input  logic                    axi_rvalid_i,
   input  logic                    axi_rlast_i,
   output logic                    axi_rready_o
);
   import axi_read_pkg::*;

   burst_ctrl_if ctrl_bus ();

   read_state_t rd_state;
   logic        align_empty;
   logic        beat_valid;

   assign axi_arid_o    = 4'h0;
   assign axi_arsize_o  = AXI_SIZE;
   assign axi_arburst_o = AXI_BURST_INCR;
   assign axi_arcache_o = AXI_CACHE;
   assign axi_arprot_o  = AXI_PROT;

   assign axi_araddr_o = ctrl_bus.burst_addr;
   assign axi_arlen_o  = ctrl_bus.burst_len;

   assign beat_valid = axi_rvalid_i && (rd_state == RD_DATA);   // Beat taken in data phase

   read_fsm u_fsm (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .req_valid_i  (m_rvalid_i),
      .align_empty_i(align_empty),
      .arready_i    (axi_arready_i),
      .rvalid_i     (axi_rvalid_i),
      .rlast_i      (axi_rlast_i),
      .arvalid_o    (axi_arvalid_o),
      .rready_o     (axi_rready_o),
      .bus          (ctrl_bus.ctrl),
      .state_o      (rd_state)
   );

   transfer_counter u_counter (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .addr_i(m_raddr_i),
      .len_i (m_rlen_i),
      .bus   (ctrl_bus.cnt)
   );

   burst_align u_align (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .offset_i    (m_raddr_i[OFFSET_W-1:0]),
      .len_i       (m_rlen_i),
      .start_i     (ctrl_bus.start_transfer),
      .beat_valid_i(beat_valid),
      .beat_data_i (axi_rdata_i),
      .word_o      (m_rdata_o),
      .word_valid_o(m_rready_o),
      .word_last_o (m_rlast_o),
      .empty_o     (align_empty)
   );

endmodule

/* test/axi_mem_model.sv */
`timescale 1ns/1ns

module axi_mem_model (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   ar_stall_i,   // Hold arready low this cycle
   input  logic                   r_gap_i,      // Hold rvalid low this cycle
   input  axi_read_pkg::addr_t    araddr_i,
   input  axi_read_pkg::axi_len_t arlen_i,
   input  logic                   arvalid_i,
   output logic                   arready_o,
   output axi_read_pkg::data_t    rdata_o,
   output logic                   rvalid_o,
   output logic                   rlast_o,
   input  logic                   rready_i
);
   import axi_read_pkg::*;

   localparam int MEM_BYTES = 8192;

   logic [7:0] mem [MEM_BYTES];
   addr_t      ar_addr_log [$];   // One entry per AR handshake
   axi_len_t   ar_len_log [$];

   logic     busy_q;
   addr_t    addr_q;
   axi_len_t left_q;              // Beats after the current one

   assign arready_o = !busy_q && !ar_stall_i;
   assign rlast_o   = (left_q == '0);
   assign rdata_o   = {mem[(addr_q + 3) % MEM_BYTES], mem[(addr_q + 2) % MEM_BYTES],
                       mem[(addr_q + 1) % MEM_BYTES], mem[addr_q % MEM_BYTES]};

   always @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q   <= 1'b0;
         rvalid_o <= 1'b0;
         addr_q   <= '0;
         left_q   <= '0;
      end else if (!busy_q) begin
         if (arvalid_i && arready_o) begin
            busy_q <= 1'b1;
            addr_q <= araddr_i;
            left_q <= arlen_i;
            ar_addr_log.push_back(araddr_i);
            ar_len_log.push_back(arlen_i);
         end
      end else if (rvalid_o && rready_i) begin
         if (rlast_o) begin
            busy_q   <= 1'b0;
            rvalid_o <= 1'b0;
         end else begin
            addr_q   <= addr_q + addr_t'(DATA_W / 8);
            left_q   <= left_q - 1'b1;
            rvalid_o <= !r_gap_i;
         end
      end else if (!rvalid_o) begin
         rvalid_o <= !r_gap_i;
      end
   end

endmodule

/* test/simple_axi_read_chk.sv */
`timescale 1ns/1ns

module simple_axi_read_chk (
   input logic                   clk_i,
   input logic                   rst_i,
   input axi_read_pkg::addr_t    axi_araddr_o,
   input axi_read_pkg::axi_len_t axi_arlen_o,
   input logic                   axi_arvalid_o,
   input logic                   axi_arready_i,
   input logic                   m_rready_o,
   input logic                   m_rlast_o
);
   import axi_read_pkg::*;

   typedef logic [BOUNDARY_W:0] page_t;

   int    violations = 0;   // Failed assertions so far
   page_t burst_end;        // First byte past the burst, within its page

   assign burst_end = page_t'(axi_araddr_o[BOUNDARY_W-1:0])
                    + page_t'({axi_arlen_o, {OFFSET_W{1'b0}}}) + page_t'(DATA_W / 8);

   ar_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_arvalid_o && !axi_arready_i |=>
         axi_arvalid_o && $stable(axi_araddr_o) && $stable(axi_arlen_o))
   else begin
      $error("AR request changed or dropped before arready");
      violations++;
   end

   ar_page: assert property (@(posedge clk_i) disable iff (rst_i)
      axi_arvalid_o |-> (axi_arlen_o < axi_len_t'(MAX_BEATS))
         && (burst_end <= page_t'(2 ** BOUNDARY_W)))
   else begin
      $error("AR burst too long or crosses a 4 KB page");
      violations++;
   end

   quiet_reset: assert property (@(posedge clk_i) rst_i |-> !m_rready_o && !m_rlast_o)
   else begin
      $error("Output strobe active during reset");
      violations++;
   end

endmodule

bind simple_axi_read simple_axi_read_chk chk_inst (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .axi_araddr_o (axi_araddr_o),
   .axi_arlen_o  (axi_arlen_o),
   .axi_arvalid_o(axi_arvalid_o),
   .axi_arready_i(axi_arready_i),
   .m_rready_o   (m_rready_o),
   .m_rlast_o    (m_rlast_o)
);

/* test/tb_simple_axi_read.sv */
`timescale 1ns/1ns

module tb_simple_axi_read;
   import axi_read_pkg::*;

   localparam int WAIT_LIMIT = 400;   // Cycles allowed per output word
   localparam int MEM_BYTES  = 8192;
   localparam int NUM_REQ    = 13;

   typedef struct packed {
      addr_t     addr;
      xfer_len_t len;
      logic      stall;               // Random slave back-pressure
   } req_t;

   // Aligned, unaligned, multi burst, page crossing, then stalled repeats
   req_t req_tab [NUM_REQ] = '{
      '{32'h0000_0000, 12'd4, 1'b0},
      '{32'h0000_0040, 12'd64, 1'b0},
      '{32'h0000_0104, 12'd20, 1'b0},
      '{32'h0000_0201, 12'd7, 1'b0},
      '{32'h0000_0302, 12'd13, 1'b0},
      '{32'h0000_0403, 12'd1, 1'b0},
      '{32'h0000_0505, 12'd33, 1'b0},
      '{32'h0000_0600, 12'd200, 1'b0},
      '{32'h0000_0ff8, 12'd40, 1'b0},
      '{32'h0000_0201, 12'd7, 1'b1},
      '{32'h0000_0600, 12'd200, 1'b1},
      '{32'h0000_0ff7, 12'd29, 1'b1},
      '{32'h0000_0040, 12'd64, 1'b1}
   };

   logic       clk_i;
   logic       rst_i;
   logic       m_rvalid_i;
   addr_t      m_raddr_i;
   xfer_len_t  m_rlen_i;
   data_t      m_rdata_o;
   logic       m_rready_o;
   logic       m_rlast_o;
   addr_t      axi_araddr_o;
   axi_len_t   axi_arlen_o;
   logic       axi_arvalid_o;
   logic       axi_arready_i;
   logic [3:0] axi_arid_o;
   logic [2:0] axi_arsize_o;
   logic [1:0] axi_arburst_o;
   logic [3:0] axi_arcache_o;
   logic [2:0] axi_arprot_o;
   data_t      axi_rdata_i;
   logic       axi_rvalid_i;
   logic       axi_rlast_i;
   logic       axi_rready_o;

   logic        stall_en;
   logic        ar_stall;
   logic        r_gap;
   logic [31:0] rand_state;
   int          ar_seen;               // AR bursts already compared

   simple_axi_read UUT (.*);

   axi_mem_model mem_model (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .ar_stall_i(ar_stall),
      .r_gap_i   (r_gap),
      .araddr_i  (axi_araddr_o),
      .arlen_i   (axi_arlen_o),
      .arvalid_i (axi_arvalid_o),
      .arready_o (axi_arready_i),
      .rdata_o   (axi_rdata_i),
      .rvalid_o  (axi_rvalid_i),
      .rlast_o   (axi_rlast_i),
      .rready_i  (axi_rready_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   function automatic logic [31:0] next_rand();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   task automatic stop_with_failure();
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_data(string name, data_t exp, data_t got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_with_failure();
      end
   endtask

   task automatic check_addr(string name, addr_t exp, addr_t got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_with_failure();
      end
   endtask

   task automatic check_len(string name, axi_len_t exp, axi_len_t got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_with_failure();
      end
   endtask

   task automatic check_flag(string name, logic exp, logic got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_with_failure();
      end
   endtask

   // Fixed AR fields, zero extended to the widest one
   task automatic check_attr(string name, logic [3:0] exp, logic [3:0] got);
      if (got !== exp) begin
         $display("error %s expected %h got %h", name, exp, got);
         stop_with_failure();
      end
   endtask

   // Word k holds bytes at base + 4k, zero past the count
   function automatic data_t expected_word(addr_t base, xfer_len_t len, int k);
      data_t w;
      int    idx;
      w = '0;
      for (int j = 0; j < DATA_W / 8; j++) begin
         idx = 4 * k + j;
         if (idx < int'(len)) begin
            w[8*j +: 8] = mem_model.mem[(base + addr_t'(idx)) % MEM_BYTES];
         end
      end
      return w;
   endfunction

   task automatic check_bursts(addr_t base, xfer_len_t len);
      addr_t a;
      int    rem;
      int    beats;
      int    page_beats;
      a   = {base[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
      rem = int'(len) + int'(base[OFFSET_W-1:0]);
      while (rem > 0) begin
         beats      = (rem + 3) / 4;
         page_beats = ((1 << BOUNDARY_W) - int'(a[BOUNDARY_W-1:0])) / 4;
         beats      = (beats > MAX_BEATS) ? MAX_BEATS : beats;
         beats      = (beats > page_beats) ? page_beats : beats;
         if (ar_seen >= mem_model.ar_addr_log.size()) begin
            $display("Read at %h issued fewer AR bursts than expected", base);
            stop_with_failure();
         end
         check_addr("axi_araddr_o", a, mem_model.ar_addr_log[ar_seen]);
         check_len("axi_arlen_o", axi_len_t'(beats - 1), mem_model.ar_len_log[ar_seen]);
         ar_seen++;
         a   = a + addr_t'(4 * beats);
         rem = rem - 4 * beats;
      end
      if (ar_seen != mem_model.ar_addr_log.size()) begin
         $display("Read at %h issued more AR bursts than expected", base);
         stop_with_failure();
      end
   endtask

   task automatic run_request(addr_t base, xfer_len_t len, logic stall);
      int nwords;
      int waited;
      nwords = (int'(len) + 3) / 4;
      @(posedge clk_i);
      #1;
      stall_en   = stall;
      m_rvalid_i = 1'b1;
      m_raddr_i  = base;
      m_rlen_i   = len;
      for (int k = 0; k < nwords; k++) begin
         waited = 0;
         @(negedge clk_i);
         while (!m_rready_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
         end
         if (!m_rready_o) begin
            $display("Timed out waiting for word %0d of the read at %h", k, base);
            stop_with_failure();
         end
         check_data("m_rdata_o", expected_word(base, len, k), m_rdata_o);
         check_flag("m_rlast_o", logic'(k == nwords - 1), m_rlast_o);
      end
      @(posedge clk_i);
      #1;
      m_rvalid_i = 1'b0;
      stall_en   = 1'b0;
      check_bursts(base, len);
      check_attr("axi_arid_o", 4'h0, axi_arid_o);
      check_attr("axi_arsize_o", 4'd2, 4'(axi_arsize_o));      // 4-byte beats
      check_attr("axi_arburst_o", 4'b0001, 4'(axi_arburst_o));  // INCR
      check_attr("axi_arcache_o", 4'(AXI_CACHE), axi_arcache_o);
      check_attr("axi_arprot_o", 4'(AXI_PROT), 4'(axi_arprot_o));
   endtask

   // Slave stall choices, one draw per cycle
   always @(posedge clk_i) begin
      logic        en;
      logic [31:0] r;
      en = stall_en;
      #1;
      r        = next_rand();
      ar_stall = en && r[31];
      r_gap    = en && (r[30:29] == 2'b00);
   end

   initial begin
      logic [31:0] r;
      rand_state = 32'h24cd355c;
      rst_i      = 1'b1;
      m_rvalid_i = 1'b0;
      m_raddr_i  = '0;
      m_rlen_i   = '0;
      stall_en   = 1'b0;
      ar_stall   = 1'b0;
      r_gap      = 1'b0;
      ar_seen    = 0;
      for (int i = 0; i < MEM_BYTES; i++) begin
         r = next_rand();
         mem_model.mem[i] = r[31:24];
      end
      repeat (5) @(posedge clk_i);
      #1;
      rst_i = 1'b0;

      repeat (10) begin   // Idle outputs before any request
         @(negedge clk_i);
         check_flag("m_rready_o", 1'b0, m_rready_o);
         check_flag("m_rlast_o", 1'b0, m_rlast_o);
      end

      foreach (req_tab[i]) begin
         run_request(req_tab[i].addr, req_tab[i].len, req_tab[i].stall);
      end

      if (UUT.chk_inst.violations == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* simple_axi_read.f */
hw/axi_read_pkg.sv
hw/burst_ctrl_if.sv
hw/read_fsm.sv
hw/transfer_counter.sv
hw/burst_align.sv
hw/simple_axi_read.sv
test/axi_mem_model.sv
test/simple_axi_read_chk.sv
test/tb_simple_axi_read.sv
